// File: cpu_queue_pkg.sv
`default_nettype none

package cpu_queue_pkg;

   // --------------------
   // host data and register map size
   // --------------------
   localparam int DATA_WIDTH = 32;
   localparam logic [DATA_WIDTH-1:0] BAD_ADDR_DATA = 32'hdead_beef;
   localparam int NUM_REGS = 9;

   // control register bits, a set bit disables the queue
   localparam int CTRL_RX_DISABLE_POS = 0;
   localparam int CTRL_TX_DISABLE_POS = 1;

   // --------------------
   // register indices
   // --------------------
   typedef enum logic [3:0] {
      REG_CONTROL          = 4'd0,
      REG_RX_PKTS_ENQUEUED = 4'd1,
      REG_RX_PKTS_DEQUEUED = 4'd2,
      REG_RX_BYTES_PUSHED  = 4'd3,
      REG_RX_PKTS_IN_QUEUE = 4'd4,
      REG_TX_PKTS_ENQUEUED = 4'd5,
      REG_TX_PKTS_DEQUEUED = 4'd6,
      REG_TX_BYTES_PUSHED  = 4'd7,
      REG_TX_PKTS_IN_QUEUE = 4'd8
   } stat_reg_e;

   // single port operations on the counter RAM
   typedef enum logic [1:0] {
      OP_NONE  = 2'd0,
      OP_CLEAR = 2'd1,
      OP_ADD   = 2'd2,
      OP_WRITE = 2'd3
   } reg_op_e;

   // controller states
   typedef enum logic {
      ST_CLEARING = 1'b0,
      ST_SWEEPING = 1'b1
   } sweep_state_e;

endpackage

`default_nettype wire

// File: cpu_queue_stats.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_queue_stats
   import cpu_queue_pkg::*;
#(
   parameter int BYTE_CNT_WIDTH = 12,
   parameter int DELTA_WIDTH    = 16,
   parameter int REG_ADDR_WIDTH = 8
) (
   input  wire logic                        clk,
   input  wire logic                        reset,

   // host register access
   input  wire logic                        reg_req,
   input  wire logic                        reg_rd_wr_l,
   input  wire logic [REG_ADDR_WIDTH-1:0]   reg_addr,
   input  wire logic [DATA_WIDTH-1:0]       reg_wr_data,
   output logic [DATA_WIDTH-1:0]            reg_rd_data,
   output logic                             reg_ack,

   // rx queue
   output logic                             rx_queue_en,
   input  wire logic                        rx_pkt_stored,
   input  wire logic                        rx_pkt_removed,
   input  wire logic [BYTE_CNT_WIDTH-1:0]   rx_pkt_byte_cnt,

   // tx queue
   output logic                             tx_queue_en,
   input  wire logic                        tx_pkt_stored,
   input  wire logic                        tx_pkt_removed,
   input  wire logic [BYTE_CNT_WIDTH-1:0]   tx_pkt_byte_cnt
);

   // --------------------
   // internal wiring
   // --------------------
   logic                          commit;
   stat_reg_e                     commit_idx;
   logic signed [DELTA_WIDTH-1:0] commit_delta;

   reg_op_e                       ram_op;
   stat_reg_e                     ram_idx;
   logic [DATA_WIDTH-1:0]         ram_operand;
   logic [DATA_WIDTH-1:0]         ram_rd_data;

   // strobes collect here until the sweep picks them up
   queue_event_deltas #(
      .BYTE_CNT_WIDTH (BYTE_CNT_WIDTH),
      .DELTA_WIDTH    (DELTA_WIDTH)
   ) u_deltas (
      .clk             (clk),
      .reset           (reset),
      .rx_pkt_stored   (rx_pkt_stored),
      .rx_pkt_removed  (rx_pkt_removed),
      .rx_pkt_byte_cnt (rx_pkt_byte_cnt),
      .tx_pkt_stored   (tx_pkt_stored),
      .tx_pkt_removed  (tx_pkt_removed),
      .tx_pkt_byte_cnt (tx_pkt_byte_cnt),
      .commit          (commit),
      .commit_idx      (commit_idx),
      .commit_delta    (commit_delta)
   );

   stat_reg_file #(
      .DELTA_WIDTH (DELTA_WIDTH)
   ) u_reg_file (
      .clk         (clk),
      .ram_op      (ram_op),
      .ram_idx     (ram_idx),
      .ram_operand (ram_operand),
      .ram_rd_data (ram_rd_data)
   );

   stat_sweep_ctrl #(
      .REG_ADDR_WIDTH (REG_ADDR_WIDTH),
      .DELTA_WIDTH    (DELTA_WIDTH)
   ) u_ctrl (
      .clk          (clk),
      .reset        (reset),
      .reg_req      (reg_req),
      .reg_rd_wr_l  (reg_rd_wr_l),
      .reg_addr     (reg_addr),
      .reg_wr_data  (reg_wr_data),
      .reg_rd_data  (reg_rd_data),
      .reg_ack      (reg_ack),
      .rx_queue_en  (rx_queue_en),
      .tx_queue_en  (tx_queue_en),
      .commit       (commit),
      .commit_idx   (commit_idx),
      .commit_delta (commit_delta),
      .ram_op       (ram_op),
      .ram_idx      (ram_idx),
      .ram_operand  (ram_operand),
      .ram_rd_data  (ram_rd_data)
   );

endmodule

`default_nettype wire

// File: queue_event_deltas.sv
`timescale 1ns/1ps
`default_nettype none

module queue_event_deltas
   import cpu_queue_pkg::*;
#(
   parameter int BYTE_CNT_WIDTH = 12,
   parameter int DELTA_WIDTH    = 16
) (
   input  wire logic                          clk,
   input  wire logic                          reset,

   // rx queue events
   input  wire logic                          rx_pkt_stored,
   input  wire logic                          rx_pkt_removed,
   input  wire logic [BYTE_CNT_WIDTH-1:0]     rx_pkt_byte_cnt,

   // tx queue events
   input  wire logic                          tx_pkt_stored,
   input  wire logic                          tx_pkt_removed,
   input  wire logic [BYTE_CNT_WIDTH-1:0]     tx_pkt_byte_cnt,

   // handover to the sweep
   input  wire logic                          commit,
   input  wire stat_reg_e                     commit_idx,
   output logic signed [DELTA_WIDTH-1:0]      commit_delta
);

   // pending change per counter
   logic signed [DELTA_WIDTH-1:0] delta_q [1:NUM_REGS-1];

   // what this cycle's strobes add to each counter
   logic signed [DELTA_WIDTH-1:0] contrib [1:NUM_REGS-1];

   // +1 on stored only and -1 on removed only
   function automatic logic signed [DELTA_WIDTH-1:0] queue_step(
      input logic stored,
      input logic removed
   );
      logic signed [DELTA_WIDTH-1:0] step;
      case ({removed, stored})
         2'b01:   step = DELTA_WIDTH'(1);
         2'b10:   step = -DELTA_WIDTH'(1);
         default: step = '0;
      endcase
      return step;
   endfunction

   // --------------------
   // per-cycle contribution
   // --------------------
   always_comb begin
      contrib[REG_RX_PKTS_ENQUEUED] = DELTA_WIDTH'(rx_pkt_stored);
      contrib[REG_RX_PKTS_DEQUEUED] = DELTA_WIDTH'(rx_pkt_removed);
      // rx byte count is valid with the remove strobe
      contrib[REG_RX_BYTES_PUSHED]  = rx_pkt_removed ? DELTA_WIDTH'(rx_pkt_byte_cnt) : '0;
      contrib[REG_RX_PKTS_IN_QUEUE] = queue_step(rx_pkt_stored, rx_pkt_removed);

      contrib[REG_TX_PKTS_ENQUEUED] = DELTA_WIDTH'(tx_pkt_stored);
      contrib[REG_TX_PKTS_DEQUEUED] = DELTA_WIDTH'(tx_pkt_removed);
      // tx byte count comes with the store strobe
      contrib[REG_TX_BYTES_PUSHED]  = tx_pkt_stored ? DELTA_WIDTH'(tx_pkt_byte_cnt) : '0;
      contrib[REG_TX_PKTS_IN_QUEUE] = queue_step(tx_pkt_stored, tx_pkt_removed);
   end

   // --------------------
   // delta registers
   // --------------------
   // committed slot restarts from this cycle's event while the others keep summing
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < NUM_REGS; i++) begin
            delta_q[i] <= '0;
         end
      end else begin
         for (int i = 1; i < NUM_REGS; i++) begin
            if (commit && commit_idx == stat_reg_e'(i)) begin
               delta_q[i] <= contrib[i];
            end else begin
               delta_q[i] <= delta_q[i] + contrib[i];
            end
         end
      end
   end

   // control index carries no delta
   assign commit_delta = (commit_idx != REG_CONTROL && commit_idx < NUM_REGS) ?
                         delta_q[commit_idx] : '0;

   // sweep only ever commits a mapped counter
   commit_idx_in_range: assert property (
      @(posedge clk) disable iff (reset)
      commit |-> (commit_idx < NUM_REGS)
   ) else $error("commit of unmapped index %0d", commit_idx);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_cpu_queue_stats -o sim_tb \
   && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "simulation passed" && exit 0 \
   || { echo "simulation failed"; exit 1; }

// File: sim.f
cpu_queue_pkg.sv
queue_event_deltas.sv
stat_reg_file.sv
stat_sweep_ctrl.sv
cpu_queue_stats.sv
stats_checker.sv
tb_cpu_queue_stats.sv

// File: stat_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module stat_reg_file
   import cpu_queue_pkg::*;
#(
   parameter int DELTA_WIDTH = 16
) (
   input  wire logic                    clk,
   input  wire reg_op_e                 ram_op,
   input  wire stat_reg_e               ram_idx,
   input  wire logic [DATA_WIDTH-1:0]   ram_operand,
   output logic [DATA_WIDTH-1:0]        ram_rd_data
);

   // counter storage, one word per register index
   logic [DATA_WIDTH-1:0] mem [NUM_REGS];

   // delta sits in the low bits of the operand
   logic [DATA_WIDTH-1:0] operand_ext;

   assign operand_ext = {{(DATA_WIDTH - DELTA_WIDTH){ram_operand[DELTA_WIDTH-1]}},
                         ram_operand[DELTA_WIDTH-1:0]};

   // --------------------
   // single operation port
   // --------------------
   always_ff @(posedge clk) begin
      case (ram_op)
         OP_CLEAR: mem[ram_idx] <= '0;
         // read-modify-write kept local to the RAM
         OP_ADD:   mem[ram_idx] <= mem[ram_idx] + operand_ext;
         OP_WRITE: mem[ram_idx] <= ram_operand;
         default: begin
         end
      endcase
   end

   // combinational read of the addressed entry
   assign ram_rd_data = (ram_idx < NUM_REGS) ? mem[ram_idx] : '0;

   // controller never issues an operation outside the map
   op_idx_in_range: assert property (
      @(posedge clk)
      (ram_op != OP_NONE) |-> (ram_idx < NUM_REGS)
   ) else $error("ram op %0d on unmapped index %0d", ram_op, ram_idx);

endmodule

`default_nettype wire

// File: stat_sweep_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stat_sweep_ctrl
   import cpu_queue_pkg::*;
#(
   parameter int REG_ADDR_WIDTH = 8,
   parameter int DELTA_WIDTH    = 16
) (
   input  wire logic                        clk,
   input  wire logic                        reset,

   // host register access
   input  wire logic                        reg_req,
   input  wire logic                        reg_rd_wr_l,
   input  wire logic [REG_ADDR_WIDTH-1:0]   reg_addr,
   input  wire logic [DATA_WIDTH-1:0]       reg_wr_data,
   output logic [DATA_WIDTH-1:0]            reg_rd_data,
   output logic                             reg_ack,

   // queue enables from the control register
   output logic                             rx_queue_en,
   output logic                             tx_queue_en,

   // delta tracker
   output logic                             commit,
   output stat_reg_e                        commit_idx,
   input  wire logic signed [DELTA_WIDTH-1:0] commit_delta,

   // counter RAM
   output reg_op_e                          ram_op,
   output stat_reg_e                        ram_idx,
   output logic [DATA_WIDTH-1:0]            ram_operand,
   input  wire logic [DATA_WIDTH-1:0]       ram_rd_data
);

   localparam stat_reg_e LAST_IDX = stat_reg_e'(NUM_REGS - 1);

   sweep_state_e          state;
   stat_reg_e             sweep_idx;
   logic                  reg_req_d1;
   logic                  new_req;
   logic                  addr_good;
   stat_reg_e             addr_idx;
   logic [DATA_WIDTH-1:0] control_q;

   // --------------------
   // request decode
   // --------------------
   assign new_req   = reg_req && !reg_req_d1;
   assign addr_good = reg_addr < REG_ADDR_WIDTH'(NUM_REGS);
   assign addr_idx  = stat_reg_e'(reg_addr[$bits(stat_reg_e)-1:0]);

   // --------------------
   // RAM port arbitration
   // --------------------
   always_comb begin
      ram_op      = OP_NONE;
      ram_idx     = sweep_idx;
      ram_operand = '0;
      commit      = 1'b0;
      commit_idx  = sweep_idx;

      case (state)
         ST_CLEARING: begin
            ram_op = OP_CLEAR;
         end
         ST_SWEEPING: begin
            if (new_req) begin
               // host owns the port and the sweep holds its place
               ram_idx = addr_idx;
               if (addr_good && !reg_rd_wr_l) begin
                  ram_op      = OP_WRITE;
                  ram_operand = reg_wr_data;
               end
            end else begin
               commit      = 1'b1;
               ram_op      = OP_ADD;
               ram_operand = {{(DATA_WIDTH - DELTA_WIDTH){commit_delta[DELTA_WIDTH-1]}},
                              commit_delta};
            end
         end
      endcase
   end

   // request one cycle back for the edge detect
   always_ff @(posedge clk) begin
      reg_req_d1 <= reg_req;
   end

   // --------------------
   // state, index and host side
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= ST_CLEARING;
         sweep_idx   <= REG_CONTROL;
         control_q   <= '0;
         reg_rd_data <= '0;
         reg_ack     <= 1'b0;
         rx_queue_en <= 1'b1;
         tx_queue_en <= 1'b1;
      end else begin
         // one ack per rising edge even while clearing
         reg_ack <= new_req;

         // enables lag the control register by a cycle
         rx_queue_en <= !control_q[CTRL_RX_DISABLE_POS];
         tx_queue_en <= !control_q[CTRL_TX_DISABLE_POS];

         case (state)
            ST_CLEARING: begin
               if (sweep_idx == LAST_IDX) begin
                  state     <= ST_SWEEPING;
                  sweep_idx <= REG_CONTROL;
               end else begin
                  sweep_idx <= stat_reg_e'(sweep_idx + 1'b1);
               end
            end
            ST_SWEEPING: begin
               if (new_req) begin
                  if (!addr_good) begin
                     reg_rd_data <= BAD_ADDR_DATA;
                  end else if (addr_idx == REG_CONTROL) begin
                     reg_rd_data <= control_q;
                  end else begin
                     reg_rd_data <= ram_rd_data;
                  end

                  if (addr_good && !reg_rd_wr_l && addr_idx == REG_CONTROL) begin
                     control_q <= reg_wr_data;
                  end
               end else if (sweep_idx == LAST_IDX) begin
                  sweep_idx <= REG_CONTROL;
               end else begin
                  sweep_idx <= stat_reg_e'(sweep_idx + 1'b1);
               end
            end
         endcase
      end
   end

   // ack is a single-cycle pulse
   ack_single_pulse: assert property (
      @(posedge clk) disable iff (reset)
      reg_ack |=> !reg_ack
   ) else $error("reg_ack high for two cycles");

endmodule

`default_nettype wire

// File: stats_checker.sv
`timescale 1ns/1ps
`default_nettype none

module stats_checker
   import cpu_queue_pkg::*;
#(
   parameter int BYTE_CNT_WIDTH = 12,
   parameter int REG_ADDR_WIDTH = 8
) (
   input  wire logic                        clk,
   input  wire logic                        reset,
   input  wire logic                        reg_req,
   input  wire logic                        reg_rd_wr_l,
   input  wire logic [REG_ADDR_WIDTH-1:0]   reg_addr,
   input  wire logic [DATA_WIDTH-1:0]       reg_wr_data,
   input  wire logic [DATA_WIDTH-1:0]       reg_rd_data,
   input  wire logic                        reg_ack,
   input  wire logic                        rx_queue_en,
   input  wire logic                        tx_queue_en,
   input  wire logic                        rx_pkt_stored,
   input  wire logic                        rx_pkt_removed,
   input  wire logic [BYTE_CNT_WIDTH-1:0]   rx_pkt_byte_cnt,
   input  wire logic                        tx_pkt_stored,
   input  wire logic                        tx_pkt_removed,
   input  wire logic [BYTE_CNT_WIDTH-1:0]   tx_pkt_byte_cnt,
   // high on reads issued after a quiet period
   input  wire logic                        read_settled,
   output int                               error_count
);

   // slot 0 unused, control lives in control_model
   logic [DATA_WIDTH-1:0]     counter_model [NUM_REGS];
   logic [DATA_WIDTH-1:0]     control_model;
   // control value one and two edges back, for the enable lag
   logic [DATA_WIDTH-1:0]     ctrl_hist1;
   logic [DATA_WIDTH-1:0]     ctrl_hist2;
   logic [DATA_WIDTH-1:0]     expected_data;
   logic [REG_ADDR_WIDTH-1:0] expected_addr;
   logic                      req_prev;
   logic                      ack_due;
   logic                      compare_due;
   logic                      reset_seen = 1'b0;
   int                        clear_cycles;
   int                        errors = 0;

   assign error_count = errors;

   function automatic logic is_counter(input logic [REG_ADDR_WIDTH-1:0] addr);
      return (addr != '0) && (addr < REG_ADDR_WIDTH'(NUM_REGS));
   endfunction

   // expected host read value from the model
   function automatic logic [DATA_WIDTH-1:0] expected_read(
      input logic [REG_ADDR_WIDTH-1:0] addr
   );
      logic [DATA_WIDTH-1:0] value;
      if (addr >= REG_ADDR_WIDTH'(NUM_REGS)) begin
         value = BAD_ADDR_DATA;
      end else if (addr == '0) begin
         value = control_model;
      end else begin
         value = counter_model[addr[3:0]];
      end
      return value;
   endfunction

   task automatic report_mismatch(
      input string                 name,
      input logic [DATA_WIDTH-1:0] got,
      input logic [DATA_WIDTH-1:0] exp
   );
      errors++;
      $display("ERROR %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
   endtask

   // --------------------
   // model and compare
   // --------------------
   always @(posedge clk) begin
      if (reset) begin
         // outputs already driven by an earlier reset edge
         if (reset_seen) begin
            if (reg_ack !== 1'b0) report_mismatch("reg_ack", 32'(reg_ack), 32'h0);
            if (reg_rd_data !== '0) report_mismatch("reg_rd_data", reg_rd_data, 32'h0);
            if (rx_queue_en !== 1'b1) report_mismatch("rx_queue_en", 32'(rx_queue_en), 32'h1);
            if (tx_queue_en !== 1'b1) report_mismatch("tx_queue_en", 32'(tx_queue_en), 32'h1);
         end
         reset_seen = 1'b1;
         for (int i = 0; i < NUM_REGS; i++) begin
            counter_model[i] = '0;
         end
         control_model = '0;
         ctrl_hist1    = '0;
         ctrl_hist2    = '0;
         ack_due       = 1'b0;
         compare_due   = 1'b0;
         clear_cycles  = 0;
      end else begin
         // response to the request seen one edge ago
         if (ack_due && reg_ack !== 1'b1) begin
            errors++;
            $display("missing reg_ack one cycle after the request to 0x%02h", expected_addr);
         end else if (!ack_due && reg_ack !== 1'b0) begin
            errors++;
            $display("reg_ack pulsed without a new request at %0t", $time);
         end
         if (compare_due && reg_rd_data !== expected_data) begin
            report_mismatch($sformatf("reg_rd_data[0x%02h]", expected_addr),
                            reg_rd_data, expected_data);
         end
         if (rx_queue_en !== !ctrl_hist2[CTRL_RX_DISABLE_POS]) begin
            report_mismatch("rx_queue_en", 32'(rx_queue_en),
                            32'(!ctrl_hist2[CTRL_RX_DISABLE_POS]));
         end
         if (tx_queue_en !== !ctrl_hist2[CTRL_TX_DISABLE_POS]) begin
            report_mismatch("tx_queue_en", 32'(tx_queue_en),
                            32'(!ctrl_hist2[CTRL_TX_DISABLE_POS]));
         end

         // new request, ignored by the block while clearing
         ack_due     = reg_req && !req_prev;
         compare_due = 1'b0;
         if (ack_due) begin
            expected_addr = reg_addr;
         end
         if (ack_due && clear_cycles >= NUM_REGS) begin
            expected_data = expected_read(reg_addr);
            compare_due   = reg_rd_wr_l && (read_settled || !is_counter(reg_addr));
            if (!reg_rd_wr_l && reg_addr == '0) begin
               control_model = reg_wr_data;
            end else if (!reg_rd_wr_l && is_counter(reg_addr)) begin
               counter_model[reg_addr[3:0]] = reg_wr_data;
            end
         end

         // queue events of this cycle, after any write
         counter_model[REG_RX_PKTS_ENQUEUED] += 32'(rx_pkt_stored);
         counter_model[REG_RX_PKTS_DEQUEUED] += 32'(rx_pkt_removed);
         if (rx_pkt_removed) counter_model[REG_RX_BYTES_PUSHED] += 32'(rx_pkt_byte_cnt);
         counter_model[REG_RX_PKTS_IN_QUEUE] += 32'(rx_pkt_stored) - 32'(rx_pkt_removed);
         counter_model[REG_TX_PKTS_ENQUEUED] += 32'(tx_pkt_stored);
         counter_model[REG_TX_PKTS_DEQUEUED] += 32'(tx_pkt_removed);
         if (tx_pkt_stored) counter_model[REG_TX_BYTES_PUSHED] += 32'(tx_pkt_byte_cnt);
         counter_model[REG_TX_PKTS_IN_QUEUE] += 32'(tx_pkt_stored) - 32'(tx_pkt_removed);

         ctrl_hist2 = ctrl_hist1;
         ctrl_hist1 = control_model;
         if (clear_cycles < NUM_REGS) clear_cycles++;
      end
      req_prev = reg_req;
   end

endmodule

`default_nettype wire

// File: tb_cpu_queue_stats.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_queue_stats
   import cpu_queue_pkg::*;
();

   localparam int BYTE_CNT_WIDTH = 12;
   localparam int DELTA_WIDTH    = 16;
   localparam int REG_ADDR_WIDTH = 8;
   localparam int CLK_HALF       = 4;
   localparam int RESET_CYCLES   = 5;
   localparam int ACK_WAIT       = 4;
   // watchdog budget
   localparam int NUM_PHASES     = 5;
   localparam int PHASE_CYCLES   = 3000;

   logic                      clk;
   logic                      reset;
   logic                      reg_req;
   logic                      reg_rd_wr_l;
   logic [REG_ADDR_WIDTH-1:0] reg_addr;
   logic [DATA_WIDTH-1:0]     reg_wr_data;
   logic [DATA_WIDTH-1:0]     reg_rd_data;
   logic                      reg_ack;
   logic                      rx_queue_en;
   logic                      tx_queue_en;
   logic                      rx_pkt_stored;
   logic                      rx_pkt_removed;
   logic [BYTE_CNT_WIDTH-1:0] rx_pkt_byte_cnt;
   logic                      tx_pkt_stored;
   logic                      tx_pkt_removed;
   logic [BYTE_CNT_WIDTH-1:0] tx_pkt_byte_cnt;
   logic                      read_settled;
   logic [31:0]               rng;
   logic [DATA_WIDTH-1:0]     rd_data;
   int                        tb_errors;
   int                        checker_errors;
   logic [DATA_WIDTH-1:0]     ctrl_values [4] = '{32'h1, 32'h2, 32'h1234_5603, 32'h0};

   cpu_queue_stats #(
      .BYTE_CNT_WIDTH (BYTE_CNT_WIDTH),
      .DELTA_WIDTH    (DELTA_WIDTH),
      .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
   ) dut (.*);

   stats_checker #(
      .BYTE_CNT_WIDTH (BYTE_CNT_WIDTH),
      .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
   ) chk (.*, .error_count (checker_errors));

   initial clk = 1'b0;
   always #(CLK_HALF) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // --------------------
   // host access
   // --------------------
   task automatic host_request(
      input  logic                      rd_wr_l,
      input  logic [REG_ADDR_WIDTH-1:0] addr,
      input  logic [DATA_WIDTH-1:0]     wr_data,
      input  logic                      settled,
      output logic [DATA_WIDTH-1:0]     data
   );
      int waited;
      @(negedge clk);
      reg_req      = 1'b1;
      reg_rd_wr_l  = rd_wr_l;
      reg_addr     = addr;
      reg_wr_data  = wr_data;
      read_settled = settled;
      waited       = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!reg_ack && waited < ACK_WAIT);
      if (!reg_ack) begin
         tb_errors++;
         $display("no reg_ack within %0d cycles of the request to 0x%02h", ACK_WAIT, addr);
      end
      data         = reg_rd_data;
      reg_req      = 1'b0;
      read_settled = 1'b0;
   endtask

   task automatic host_read(
      input  logic [REG_ADDR_WIDTH-1:0] addr,
      input  logic                      settled,
      output logic [DATA_WIDTH-1:0]     data
   );
      host_request(1'b1, addr, '0, settled, data);
   endtask

   task automatic host_write(
      input logic [REG_ADDR_WIDTH-1:0] addr,
      input logic [DATA_WIDTH-1:0]     wr_data
   );
      logic [DATA_WIDTH-1:0] ignored;
      host_request(1'b0, addr, wr_data, 1'b0, ignored);
   endtask

   // long enough for every pending delta to reach the RAM
   task automatic settle();
      repeat (2 * NUM_REGS) @(negedge clk);
   endtask

   task automatic readback_all();
      logic [DATA_WIDTH-1:0] data;
      for (int i = 0; i < NUM_REGS; i++) begin
         settle();
         host_read(REG_ADDR_WIDTH'(i), 1'b1, data);
      end
   endtask

   // rx removes outrun stores, byte counts kept to 11 bits
   task automatic drive_random_events(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         rng             = xorshift32(rng);
         rx_pkt_stored   = rng[1:0] == 2'b00;
         rx_pkt_removed  = rng[3:2] != 2'b00;
         tx_pkt_stored   = rng[4];
         tx_pkt_removed  = rng[5];
         rng             = xorshift32(rng);
         rx_pkt_byte_cnt = BYTE_CNT_WIDTH'(rng[10:0]);
         tx_pkt_byte_cnt = BYTE_CNT_WIDTH'(rng[26:16]);
      end
      @(negedge clk);
      rx_pkt_stored  = 1'b0;
      rx_pkt_removed = 1'b0;
      tx_pkt_stored  = 1'b0;
      tx_pkt_removed = 1'b0;
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial begin
      reset           = 1'b1;
      reg_req         = 1'b0;
      reg_rd_wr_l     = 1'b1;
      reg_addr        = '0;
      reg_wr_data     = '0;
      rx_pkt_stored   = 1'b0;
      rx_pkt_removed  = 1'b0;
      rx_pkt_byte_cnt = '0;
      tx_pkt_stored   = 1'b0;
      tx_pkt_removed  = 1'b0;
      tx_pkt_byte_cnt = '0;
      read_settled    = 1'b0;
      rng             = 32'hd137;
      tb_errors       = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // everything reads zero once clearing is done
      repeat (NUM_REGS) @(negedge clk);
      readback_all();

      // random traffic with unsettled reads in between
      fork
         drive_random_events(1200);
         begin
            for (int i = 0; i < 60; i++) begin
               host_read(REG_ADDR_WIDTH'(i % 12), 1'b0, rd_data);
               repeat (15) @(negedge clk);
            end
         end
      join
      readback_all();
      settle();
      host_read(REG_ADDR_WIDTH'(REG_RX_PKTS_IN_QUEUE), 1'b1, rd_data);
      if (!rd_data[DATA_WIDTH-1]) begin
         tb_errors++;
         $display("rx packets in queue did not wrap below zero, read 0x%08h", rd_data);
      end

      // counter writes followed by more traffic
      settle();
      host_write(REG_ADDR_WIDTH'(REG_TX_BYTES_PUSHED), 32'h7fff_f000);
      host_write(REG_ADDR_WIDTH'(REG_RX_PKTS_DEQUEUED), 32'hffff_ffa0);
      drive_random_events(300);
      readback_all();

      // queue disables, enables are followed by the checker
      foreach (ctrl_values[i]) begin
         host_write(REG_ADDR_WIDTH'(REG_CONTROL), ctrl_values[i]);
         settle();
         host_read(REG_ADDR_WIDTH'(REG_CONTROL), 1'b1, rd_data);
      end

      // unmapped addresses
      for (int a = NUM_REGS; a < 2 ** REG_ADDR_WIDTH; a++) begin
         host_read(REG_ADDR_WIDTH'(a), 1'b0, rd_data);
      end
      host_write('1, 32'h5555_aaaa);
      readback_all();

      settle();
      $display("run complete: %0d errors (checker %0d, testbench %0d)",
               checker_errors + tb_errors, checker_errors, tb_errors);
      if (checker_errors + tb_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      repeat (NUM_PHASES * PHASE_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, run did not complete",
               NUM_PHASES * PHASE_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
